// ==== include/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// first fetch address after reset
`define CPU_RESET_PC 32'h1c00_0000

// data and address width
`define CPU_XLEN 32

// general registers, r0 reads as zero
`define CPU_NREGS 32

`endif

// ==== hdl/cpu_pkg.sv ====
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

    // instruction class seen by the later stages
    typedef enum logic [2:0] {
        OP_NOP,
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH
    } op_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        word_t       pc;
        logic [31:0] inst;
    } fs_to_ds_t;

    typedef struct packed {
        word_t    pc;
        op_e      op;
        alu_op_e  alu_op;
        word_t    a;
        word_t    b;
        word_t    st_data;
        reg_idx_t dest;
        logic     rf_we;
    } ds_to_es_t;

    typedef struct packed {
        word_t    pc;
        op_e      op;
        word_t    result;
        reg_idx_t dest;
        logic     rf_we;
    } es_to_ms_t;

    typedef struct packed {
        word_t    pc;
        word_t    wdata;
        reg_idx_t dest;
        logic     rf_we;
    } ms_to_ws_t;

    // register file write port, back from writeback
    typedef struct packed {
        logic     we;
        reg_idx_t num;
        word_t    data;
    } wb_t;

endpackage

// ==== hdl/pipe_ctrl.sv ====
`timescale 1ns/1ps

module pipe_ctrl import cpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     fs_go,
    input  reg_idx_t ds_rs1,
    input  reg_idx_t ds_rs2,
    input  logic     ds_uses_rs2,
    input  reg_idx_t es_dest,
    input  reg_idx_t ms_dest,
    input  reg_idx_t ws_dest,
    input  logic     br_taken,
    output logic     fs_valid,
    output logic     ds_valid,
    output logic     es_valid,
    output logic     ms_valid,
    output logic     ws_valid,
    output logic     fs_allowin,
    output logic     ds_allowin,
    output logic     es_allowin,
    output logic     ms_allowin,
    output logic     ds_stall
);

    logic rs1_hit;
    logic rs2_hit;

    // dest numbers arrive as zero when the stage holds no writer
    assign rs1_hit = (ds_rs1 != '0) &&
                     (ds_rs1 == es_dest || ds_rs1 == ms_dest || ds_rs1 == ws_dest);
    assign rs2_hit = ds_uses_rs2 && (ds_rs2 != '0) &&
                     (ds_rs2 == es_dest || ds_rs2 == ms_dest || ds_rs2 == ws_dest);
    assign ds_stall = ds_valid && (rs1_hit || rs2_hit);

    // writeback retires every cycle so memory always moves on
    assign ms_allowin = 1'b1;
    assign es_allowin = !es_valid || ms_allowin;
    assign ds_allowin = !ds_valid || (!ds_stall && es_allowin);
    assign fs_allowin = !fs_valid || ds_allowin;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fs_valid <= 1'b0;
            ds_valid <= 1'b0;
            es_valid <= 1'b0;
            ms_valid <= 1'b0;
            ws_valid <= 1'b0;
        end else begin
            if (fs_allowin) begin
                fs_valid <= fs_go;
            end
            // wrong-path word behind a taken branch dies here
            if (ds_allowin) begin
                ds_valid <= fs_valid && !br_taken;
            end
            // a stalled decode sends a bubble
            if (es_allowin) begin
                es_valid <= ds_valid && !ds_stall;
            end
            if (ms_allowin) begin
                ms_valid <= es_valid;
            end
            ws_valid <= ms_valid;
        end
    end

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       fs_allowin,
    input  logic       br_taken,
    input  word_t      br_target,
    output logic       fs_go,
    output logic       inst_sram_en,
    output logic [3:0] inst_sram_we,
    output word_t      inst_sram_addr,
    output word_t      inst_sram_wdata,
    input  word_t      inst_sram_rdata,
    output fs_to_ds_t  fs_to_ds
);

    word_t fs_pc;
    word_t next_pc;

    // while stalled the same address is read again so rdata holds
    assign next_pc = br_taken   ? br_target :
                     fs_allowin ? fs_pc + 32'd4 : fs_pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fs_go <= 1'b0;
            // one word before the reset pc, so next_pc starts there
            fs_pc <= `CPU_RESET_PC - 32'd4;
        end else begin
            fs_go <= 1'b1;
            if (fs_go) begin
                fs_pc <= next_pc;
            end
        end
    end

    assign inst_sram_en    = fs_go;
    assign inst_sram_we    = 4'h0;
    assign inst_sram_addr  = next_pc;
    assign inst_sram_wdata = '0;

    assign fs_to_ds.pc   = fs_pc;
    assign fs_to_ds.inst = inst_sram_rdata;

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      ds_valid,
    input  logic      ds_stall,
    input  fs_to_ds_t fs_to_ds,
    input  wb_t       wb,
    output reg_idx_t  ds_rs1,
    output reg_idx_t  ds_rs2,
    output logic      ds_uses_rs2,
    output logic      br_taken,
    output word_t     br_target,
    output ds_to_es_t ds_to_es
);

    fs_to_ds_t   ds_r;
    logic [31:0] inst;
    word_t       rf [`CPU_NREGS];
    reg_idx_t    rd;
    reg_idx_t    rj;
    reg_idx_t    rk;
    word_t       rj_val;
    word_t       rs2_val;
    word_t       si12;
    word_t       ui20;
    word_t       offs16;
    word_t       offs26;
    logic        is_add, is_sub, is_and, is_or, is_addi, is_lu12i;
    logic        is_ld, is_st, is_beq, is_bne, is_b;
    logic        is_3r;
    logic        br_cond;
    op_e         op;
    alu_op_e     alu_op;

    // held in place while stalled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ds_r <= '0;
        end else if (!ds_stall) begin
            ds_r <= fs_to_ds;
        end
    end

    assign inst = ds_r.inst;
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];

    assign is_add   = inst[31:15] == 17'h00020;
    assign is_sub   = inst[31:15] == 17'h00022;
    assign is_and   = inst[31:15] == 17'h00029;
    assign is_or    = inst[31:15] == 17'h0002a;
    assign is_addi  = inst[31:22] == 10'h00a;
    assign is_ld    = inst[31:22] == 10'h0a2;
    assign is_st    = inst[31:22] == 10'h0a6;
    assign is_lu12i = inst[31:25] == 7'h0a;
    assign is_beq   = inst[31:26] == 6'h16;
    assign is_bne   = inst[31:26] == 6'h17;
    assign is_b     = inst[31:26] == 6'h14;
    assign is_3r    = is_add | is_sub | is_and | is_or;

    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign ui20   = {inst[24:5], 12'h000};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        op     = OP_NOP;
        alu_op = ALU_ADD;
        if (is_3r | is_addi | is_lu12i) begin
            op = OP_ALU;
        end else if (is_ld) begin
            op = OP_LOAD;
        end else if (is_st) begin
            op = OP_STORE;
        end else if (is_beq | is_bne | is_b) begin
            op = OP_BRANCH;
        end
        if (is_sub) begin
            alu_op = ALU_SUB;
        end else if (is_and) begin
            alu_op = ALU_AND;
        end else if (is_or) begin
            alu_op = ALU_OR;
        end else if (is_lu12i) begin
            alu_op = ALU_LUI;
        end
    end

    // source numbers for the hazard check, rj zeroed when unused
    assign ds_rs1      = (is_3r | is_addi | is_ld | is_st | is_beq | is_bne) ? rj : '0;
    assign ds_rs2      = is_3r ? rk : rd;
    assign ds_uses_rs2 = is_3r | is_st | is_beq | is_bne;

    // write in the same cycle is seen by the read
    assign rj_val  = (rj == '0) ? '0 :
                     (wb.we && wb.num == rj) ? wb.data : rf[rj];
    assign rs2_val = (ds_rs2 == '0) ? '0 :
                     (wb.we && wb.num == ds_rs2) ? wb.data : rf[ds_rs2];

    always_ff @(posedge clk) begin
        if (wb.we && wb.num != '0) begin
            rf[wb.num] <= wb.data;
        end
    end

    assign br_cond   = is_b | (is_beq & (rj_val == rs2_val)) | (is_bne & (rj_val != rs2_val));
    assign br_taken  = ds_valid && !ds_stall && br_cond;
    assign br_target = ds_r.pc + (is_b ? offs26 : offs16);

    always_comb begin
        ds_to_es.pc      = ds_r.pc;
        ds_to_es.op      = op;
        ds_to_es.alu_op  = alu_op;
        ds_to_es.a       = rj_val;
        ds_to_es.b       = is_3r ? rs2_val : (is_lu12i ? ui20 : si12);
        ds_to_es.st_data = rs2_val;
        ds_to_es.dest    = rd;
        ds_to_es.rf_we   = is_3r | is_addi | is_lu12i | is_ld;
    end

endmodule

// ==== hdl/exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage import cpu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       es_valid,
    input  ds_to_es_t  ds_to_es,
    output reg_idx_t   es_dest,
    output logic       data_sram_en,
    output logic [3:0] data_sram_we,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    output es_to_ms_t  es_to_ms
);

    ds_to_es_t es_r;
    word_t     result;
    logic      is_mem;

    // memory never blocks, so execute takes a new entry every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            es_r <= '0;
        end else begin
            es_r <= ds_to_es;
        end
    end

    always_comb begin
        case (es_r.alu_op)
            ALU_SUB: result = es_r.a - es_r.b;
            ALU_AND: result = es_r.a & es_r.b;
            ALU_OR:  result = es_r.a | es_r.b;
            ALU_LUI: result = es_r.b;
            default: result = es_r.a + es_r.b;
        endcase
    end

    // ld.w / st.w address is rj + si12 out of the adder
    assign is_mem          = (es_r.op == OP_LOAD) || (es_r.op == OP_STORE);
    assign data_sram_en    = es_valid && is_mem;
    assign data_sram_we    = (es_valid && es_r.op == OP_STORE) ? 4'hf : 4'h0;
    assign data_sram_addr  = result;
    assign data_sram_wdata = es_r.st_data;

    assign es_dest = (es_valid && es_r.rf_we) ? es_r.dest : '0;

    always_comb begin
        es_to_ms.pc     = es_r.pc;
        es_to_ms.op     = es_r.op;
        es_to_ms.result = result;
        es_to_ms.dest   = es_r.dest;
        es_to_ms.rf_we  = es_r.rf_we;
    end

endmodule

// ==== hdl/mem_wb_stage.sv ====
`timescale 1ns/1ps

module mem_wb_stage import cpu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       ms_valid,
    input  logic       ws_valid,
    input  es_to_ms_t  es_to_ms,
    input  word_t      data_sram_rdata,
    output reg_idx_t   ms_dest,
    output reg_idx_t   ws_dest,
    output wb_t        wb,
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    es_to_ms_t ms_r;
    ms_to_ws_t ms_to_ws;
    ms_to_ws_t ws_r;
    logic      ws_write;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ms_r <= '0;
            ws_r <= '0;
        end else begin
            ms_r <= es_to_ms;
            ws_r <= ms_to_ws;
        end
    end

    // load data shows up one cycle after execute sent the address
    always_comb begin
        ms_to_ws.pc    = ms_r.pc;
        ms_to_ws.wdata = (ms_r.op == OP_LOAD) ? data_sram_rdata : ms_r.result;
        ms_to_ws.dest  = ms_r.dest;
        ms_to_ws.rf_we = ms_r.rf_we;
    end

    assign ms_dest  = (ms_valid && ms_r.rf_we) ? ms_r.dest : '0;
    assign ws_dest  = (ws_valid && ws_r.rf_we) ? ws_r.dest : '0;
    assign ws_write = ws_valid && ws_r.rf_we && (ws_r.dest != '0);

    always_comb begin
        wb.we   = ws_write;
        wb.num  = ws_r.dest;
        wb.data = ws_r.wdata;
    end

    // trace port mirrors the register file write
    assign debug_wb_pc       = ws_r.pc;
    assign debug_wb_rf_we    = {4{ws_write}};
    assign debug_wb_rf_wnum  = ws_r.dest;
    assign debug_wb_rf_wdata = ws_r.wdata;

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    // instruction sram
    output logic       inst_sram_en,
    output logic [3:0] inst_sram_we,
    output word_t      inst_sram_addr,
    output word_t      inst_sram_wdata,
    input  word_t      inst_sram_rdata,
    // data sram
    output logic       data_sram_en,
    output logic [3:0] data_sram_we,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  word_t      data_sram_rdata,
    // trace debug port
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    // handshake and hazard wiring
    logic     fs_go;
    logic     fs_valid;
    logic     ds_valid;
    logic     es_valid;
    logic     ms_valid;
    logic     ws_valid;
    logic     fs_allowin;
    logic     ds_stall;
    reg_idx_t ds_rs1;
    reg_idx_t ds_rs2;
    logic     ds_uses_rs2;
    reg_idx_t es_dest;
    reg_idx_t ms_dest;
    reg_idx_t ws_dest;
    logic     br_taken;
    word_t    br_target;

    // stage payloads
    fs_to_ds_t fs_to_ds;
    ds_to_es_t ds_to_es;
    es_to_ms_t es_to_ms;
    wb_t       wb;

    // downstream allowins are only needed inside the control block
    pipe_ctrl u_pipe_ctrl (
        .*,
        .ds_allowin (),
        .es_allowin (),
        .ms_allowin ()
    );

    fetch_stage u_fetch_stage (.*);

    decode_stage u_decode_stage (.*);

    exec_stage u_exec_stage (.*);

    mem_wb_stage u_mem_wb_stage (.*);

endmodule

// ==== dv/cpu_properties.sv ====
`timescale 1ns/1ps

module cpu_properties import cpu_pkg::*; (
    input logic       clk,
    input logic       arst_n,
    input logic       inst_sram_en,
    input logic       data_sram_en,
    input logic [3:0] data_sram_we,
    input logic [3:0] debug_wb_rf_we,
    input reg_idx_t   debug_wb_rf_wnum
);

    // core stays silent while reset is held
    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!inst_sram_en && !data_sram_en && debug_wb_rf_we == 4'h0))
        else $error("SRAM enable or trace write during reset");

    we_needs_en: assert property (@(posedge clk) disable iff (!arst_n)
        (data_sram_we != 4'h0) |-> data_sram_en)
        else $error("data SRAM write strobe without enable");

    // r0 writes never reach the trace port
    no_r0_trace: assert property (@(posedge clk) disable iff (!arst_n)
        (debug_wb_rf_we != 4'h0) |-> (debug_wb_rf_wnum != '0))
        else $error("trace reports a write to r0");

endmodule

// ==== dv/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int WAIT_LIMIT   = 60;
    localparam int DRAIN_CYCLES = 40;

    // loongarch opcode fields
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002a;
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;
    localparam logic [9:0]  OPC_LD_W   = 10'h0a2;
    localparam logic [9:0]  OPC_ST_W   = 10'h0a6;
    localparam logic [5:0]  OPC_BEQ    = 6'h16;
    localparam logic [5:0]  OPC_BNE    = 6'h17;

    logic       clk;
    logic       arst_n;
    logic       inst_sram_en;
    logic [3:0] inst_sram_we;
    word_t      inst_sram_addr;
    word_t      inst_sram_wdata;
    word_t      inst_sram_rdata = '0;
    logic       data_sram_en;
    logic [3:0] data_sram_we;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_sram_rdata = '0;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t    imem [64];
    word_t    dmem [256];
    word_t    exp_pc [$];
    reg_idx_t exp_num [$];
    word_t    exp_data [$];
    int       n_pass;
    int       n_fail;
    word_t    wmask;

    bind cpu_top cpu_properties u_cpu_properties (.*);

    cpu_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // both srams return data one cycle after the enable
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= imem[inst_sram_addr[7:2]];
        end
    end

    assign wmask = {{8{data_sram_we[3]}}, {8{data_sram_we[2]}},
                    {8{data_sram_we[1]}}, {8{data_sram_we[0]}}};

    always @(posedge clk) begin
        if (data_sram_en) begin
            dmem[data_sram_addr[9:2]] <= (dmem[data_sram_addr[9:2]] & ~wmask) |
                                         (data_sram_wdata & wmask);
            data_sram_rdata <= dmem[data_sram_addr[9:2]];
        end
    end

    function automatic word_t enc_3r(input logic [16:0] opc, input int rd, input int rj,
                                     input int rk);
        return {opc, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t enc_ri12(input logic [9:0] opc, input int rd, input int rj,
                                       input int imm);
        return {opc, imm[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t enc_lu12i(input int rd, input int imm);
        return {7'h0a, imm[19:0], rd[4:0]};
    endfunction

    // offsets count words from the branch itself
    function automatic word_t enc_br(input logic [5:0] opc, input int rj, input int rd,
                                     input int offs);
        return {opc, offs[15:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t enc_b(input int offs);
        return {6'h14, offs[15:0], offs[25:16]};
    endfunction

    task automatic expect_write(input int idx, input int num, input word_t data);
        exp_pc.push_back(`CPU_RESET_PC + 32'(idx * 4));
        exp_num.push_back(reg_idx_t'(num));
        exp_data.push_back(data);
    endtask

    task automatic build_tables();
        word_t prog [$];
        // 0..2 immediates
        prog.push_back(enc_ri12(OPC_ADDI_W, 1, 0, 'h123));
        prog.push_back(enc_ri12(OPC_ADDI_W, 2, 0, -5));
        prog.push_back(enc_lu12i(3, 'h12345));
        // 3..6 each one reads a result still in flight
        prog.push_back(enc_3r(OPC_ADD_W, 4, 1, 2));
        prog.push_back(enc_3r(OPC_SUB_W, 5, 3, 4));
        prog.push_back(enc_3r(OPC_AND, 6, 5, 3));
        prog.push_back(enc_3r(OPC_OR, 7, 6, 1));
        // 7..8 r0 as destination, then as source
        prog.push_back(enc_ri12(OPC_ADDI_W, 0, 1, 1));
        prog.push_back(enc_3r(OPC_ADD_W, 8, 0, 1));
        // 9..12 store and load back, then a preloaded word
        prog.push_back(enc_ri12(OPC_ADDI_W, 9, 0, 'h100));
        prog.push_back(enc_ri12(OPC_ST_W, 7, 9, 8));
        prog.push_back(enc_ri12(OPC_LD_W, 10, 9, 8));
        prog.push_back(enc_ri12(OPC_LD_W, 11, 0, 'h20));
        // 13..15 taken beq over two words
        prog.push_back(enc_br(OPC_BEQ, 1, 8, 3));
        prog.push_back(enc_ri12(OPC_ADDI_W, 12, 0, 'h666));
        prog.push_back(enc_ri12(OPC_ADDI_W, 12, 0, 'h777));
        // 16..17 bne falls through
        prog.push_back(enc_br(OPC_BNE, 1, 8, 2));
        prog.push_back(enc_ri12(OPC_ADDI_W, 13, 0, 'haa));
        // 18..20 b over one word
        prog.push_back(enc_b(2));
        prog.push_back(enc_ri12(OPC_ADDI_W, 13, 0, 'h555));
        prog.push_back(enc_3r(OPC_OR, 14, 13, 10));
        // park on a jump to itself
        prog.push_back(enc_b(0));
        for (int i = 0; i < 64; i++) begin
            imem[i[5:0]] = '0;
        end
        for (int i = 0; i < prog.size(); i++) begin
            imem[i[5:0]] = prog[i];
        end
        expect_write(0, 1, 32'h0000_0123);
        expect_write(1, 2, 32'hffff_fffb);
        expect_write(2, 3, 32'h1234_5000);
        expect_write(3, 4, 32'h0000_011e);
        expect_write(4, 5, 32'h1234_4ee2);
        expect_write(5, 6, 32'h1234_4000);
        expect_write(6, 7, 32'h1234_4123);
        expect_write(8, 8, 32'h0000_0123);
        expect_write(9, 9, 32'h0000_0100);
        expect_write(11, 10, 32'h1234_4123);
        expect_write(12, 11, dmem[8'h08]);
        expect_write(17, 13, 32'h0000_00aa);
        expect_write(20, 14, 32'h1234_41ab);
    endtask

    task automatic log_result(input string name, input bit ok);
        if (ok) begin
            n_pass++;
            $display("%s: pass", name);
        end else begin
            n_fail++;
            $display("%s: FAIL", name);
        end
    endtask

    task automatic check_first_fetch();
        int cycles;
        bit ok;
        cycles = 0;
        ok     = 1'b1;
        do begin
            @(negedge clk);
            cycles++;
            if (debug_wb_rf_we != 4'h0) begin
                $display("register write reported before the first fetch");
                ok = 1'b0;
            end
        end while (!inst_sram_en && cycles < WAIT_LIMIT);
        if (!inst_sram_en) begin
            $display("instruction SRAM was never enabled after reset");
            ok = 1'b0;
        end else begin
            assert (inst_sram_addr == `CPU_RESET_PC) else begin
                $display("[ERROR] inst_sram_addr: got %h expected %h",
                         inst_sram_addr, `CPU_RESET_PC);
                ok = 1'b0;
            end
            // instruction port is read only
            assert (inst_sram_we == 4'h0) else begin
                $display("[ERROR] inst_sram_we: got %h expected %h", inst_sram_we, 4'h0);
                ok = 1'b0;
            end
            assert (inst_sram_wdata == '0) else begin
                $display("[ERROR] inst_sram_wdata: got %h expected %h",
                         inst_sram_wdata, 32'h0);
                ok = 1'b0;
            end
        end
        log_result("first fetch", ok);
    endtask

    task automatic check_trace();
        int cycles;
        bit ok;
        for (int row = 0; row < exp_pc.size(); row++) begin
            cycles = 0;
            ok     = 1'b1;
            do begin
                @(negedge clk);
                cycles++;
            end while (debug_wb_rf_we == 4'h0 && cycles < WAIT_LIMIT);
            if (debug_wb_rf_we == 4'h0) begin
                $display("no register write for trace row %0d within %0d cycles",
                         row, WAIT_LIMIT);
                log_result($sformatf("trace row %0d", row), 1'b0);
                break;
            end
            assert (debug_wb_rf_we == 4'hf) else begin
                $display("[ERROR] debug_wb_rf_we: got %h expected %h", debug_wb_rf_we, 4'hf);
                ok = 1'b0;
            end
            assert (debug_wb_pc == exp_pc[row]) else begin
                $display("[ERROR] debug_wb_pc: got %h expected %h", debug_wb_pc, exp_pc[row]);
                ok = 1'b0;
            end
            assert (debug_wb_rf_wnum == exp_num[row]) else begin
                $display("[ERROR] debug_wb_rf_wnum: got %h expected %h",
                         debug_wb_rf_wnum, exp_num[row]);
                ok = 1'b0;
            end
            assert (debug_wb_rf_wdata == exp_data[row]) else begin
                $display("[ERROR] debug_wb_rf_wdata: got %h expected %h",
                         debug_wb_rf_wdata, exp_data[row]);
                ok = 1'b0;
            end
            log_result($sformatf("trace row %0d pc %h", row, exp_pc[row]), ok);
        end
    endtask

    // the core parks on its self jump, so nothing more may retire
    task automatic check_quiet_tail();
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            @(negedge clk);
            if (debug_wb_rf_we != 4'h0) begin
                $display("unexpected register write to r%0d from pc %h",
                         debug_wb_rf_wnum, debug_wb_pc);
                ok = 1'b0;
            end
        end
        log_result("no writes after the program", ok);
    endtask

    initial begin
        n_pass   = 0;
        n_fail   = 0;
        arst_n   = 1'b0;
        // the seeding call also gives the first word
        dmem[0]  = $urandom(32'h7455_a73d);
        for (int i = 1; i < 256; i++) begin
            dmem[i[7:0]] = $urandom;
        end
        build_tables();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        check_first_fetch();
        check_trace();
        check_quiet_tail();
        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
hdl/cpu_pkg.sv
hdl/pipe_ctrl.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/exec_stage.sv
hdl/mem_wb_stage.sv
hdl/cpu_top.sv
dv/cpu_properties.sv
dv/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module cpu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcpu_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" sim.log; then
    exit 0
fi
exit 1
